/* compile.f */
logic/arp_pkg.sv
logic/arp_rx_parser.sv
logic/arp_tx_framer.sv
logic/arp_cache.sv
logic/arp_resolver.sv
logic/arp_engine.sv
verif/arp_checker.sv
verif/arp_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module arp_tb -f compile.f -o arp_sim
out="$(./obj_dir/arp_sim)"
echo "$out"

if grep -Fqx '>>> PASS' <<< "$out"; then
  exit 0
fi
exit 1

/* verif/arp_tb.sv */
module arp_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TABLE_DEPTH   = 8;
  localparam int TIMEOUT_TICKS = 300;
  localparam int NUM_ROWS      = 13;
  localparam int LIMIT         = NUM_ROWS * (TIMEOUT_TICKS + 200);
  localparam int LOOKUP_WAIT   = TIMEOUT_TICKS + 200;
  localparam int FRAME_WAIT    = 200;
  localparam int QUIET         = 80; // Window in which no frame may leave
  localparam int GAP           = 20;
  localparam int NAME_W        = 128;

  localparam int K_INJECT  = 0;
  localparam int K_LOOKUP  = 1;
  localparam int K_NOREPLY = 2;

  localparam arp_pkg::mac_addr_t DEV_MAC = 48'h0200_0000_0001;
  localparam arp_pkg::ipv4_t     DEV_IP  = 32'h0a00_0001;
  localparam arp_pkg::ipv4_t     IP_A    = 32'h0a00_0002;
  localparam arp_pkg::ipv4_t     IP_B    = 32'h0a00_0003;
  localparam arp_pkg::ipv4_t     IP_C    = 32'h0a00_0004;
  localparam arp_pkg::ipv4_t     IP_D    = 32'h0a00_0005;
  localparam arp_pkg::ipv4_t     IP_E    = 32'h0a00_0006;
  localparam arp_pkg::ipv4_t     IP_F    = 32'h0a00_0009;
  localparam arp_pkg::ipv4_t     IP_X    = 32'h0a00_004d; // Not ours

  typedef struct packed {
    logic [NAME_W-1:0]  name;
    int                 kind;
    arp_pkg::arp_oper_t op;
    arp_pkg::mac_addr_t smac;
    arp_pkg::ipv4_t     sip;
    arp_pkg::ipv4_t     tip;
    int                 nbytes;
    int                 err_at; // -1 for a clean frame
    logic               exp_frame;
    arp_pkg::arp_hdr_t  exp_hdr;
    arp_pkg::mac_addr_t exp_dst;
    logic               chk_result;
    logic               exp_val;
    logic               exp_err;
    arp_pkg::mac_addr_t exp_mac;
  } row_t;

  logic               clk = 1'b0;
  logic               rst;
  arp_pkg::dev_t      dev;
  arp_pkg::rx_beat_t  rx;
  arp_pkg::tx_beat_t  tx;
  arp_pkg::mac_addr_t dst_mac;
  logic               tx_rdy;
  logic               tx_req;
  arp_pkg::ipv4_t     ipv4;
  logic               req;
  arp_pkg::mac_addr_t mac;
  logic               val;
  logic               err;
  logic               check_stb;
  int                 pass_cnt;
  int                 fail_cnt;
  int                 cycles = 0;
  logic [15:0]        lfsr = 16'd37;
  row_t               rows [NUM_ROWS];
  row_t               cur;
  arp_pkg::mac_addr_t mac_a;
  arp_pkg::mac_addr_t mac_a2;
  arp_pkg::mac_addr_t mac_b;
  arp_pkg::mac_addr_t mac_c;
  arp_pkg::mac_addr_t mac_d;
  arp_pkg::mac_addr_t mac_e;

  arp_engine #(
    .TABLE_DEPTH   (TABLE_DEPTH),
    .TIMEOUT_TICKS (TIMEOUT_TICKS)
  ) dut0 (
    .clk     (clk),
    .rst     (rst),
    .dev     (dev),
    .rx      (rx),
    .tx      (tx),
    .dst_mac (dst_mac),
    .tx_rdy  (tx_rdy),
    .tx_req  (tx_req),
    .ipv4    (ipv4),
    .req     (req),
    .mac     (mac),
    .val     (val),
    .err     (err)
  );

  arp_checker chk0 (
    .clk        (clk),
    .rst        (rst),
    .tx         (tx),
    .dst_mac    (dst_mac),
    .tx_rdy     (tx_rdy),
    .tx_req     (tx_req),
    .mac        (mac),
    .val        (val),
    .err        (err),
    .check_stb  (check_stb),
    .name       (cur.name),
    .exp_frame  (cur.exp_frame),
    .exp_hdr    (cur.exp_hdr),
    .exp_dst    (cur.exp_dst),
    .chk_result (cur.chk_result),
    .exp_val    (cur.exp_val),
    .exp_err    (cur.exp_err),
    .exp_mac    (cur.exp_mac),
    .pass_cnt   (pass_cnt),
    .fail_cnt   (fail_cnt)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == LIMIT) begin
      $display("Timeout: tests did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic arp_pkg::mac_addr_t random_mac();
    arp_pkg::mac_addr_t m;
    m = '0;
    for (int i = 0; i < 48; i++) begin
      lfsr = lfsr_next(lfsr);
      m    = {m[46:0], lfsr[0]};
    end
    m[40] = 1'b0; // Unicast
    return m;
  endfunction

  function automatic arp_pkg::arp_hdr_t make_hdr(input arp_pkg::arp_oper_t op,
                                                 input arp_pkg::mac_addr_t smac,
                                                 input arp_pkg::ipv4_t sip,
                                                 input arp_pkg::mac_addr_t tmac,
                                                 input arp_pkg::ipv4_t tip);
    return '{hw_type: arp_pkg::HW_TYPE_ETH, proto: arp_pkg::PROTO_IPV4,
             hlen: arp_pkg::HW_LEN, plen: arp_pkg::PROTO_LEN, oper: op,
             src_mac: smac, src_ipv4: sip, dst_mac: tmac, dst_ipv4: tip};
  endfunction

  // A miss sends a broadcast request first
  function automatic row_t miss_row(input logic [NAME_W-1:0] nm, input arp_pkg::ipv4_t ip,
                                    input arp_pkg::mac_addr_t rmac, input logic reply);
    row_t r;
    r            = '0;
    r.name       = nm;
    r.kind       = reply ? K_LOOKUP : K_NOREPLY;
    r.sip        = ip;
    r.smac       = rmac;
    r.exp_frame  = 1'b1;
    r.exp_hdr    = make_hdr(arp_pkg::OPER_REQUEST, DEV_MAC, DEV_IP, '0, ip);
    r.exp_dst    = arp_pkg::BROADCAST_MAC;
    r.chk_result = 1'b1;
    r.exp_val    = reply;
    r.exp_err    = !reply;
    r.exp_mac    = rmac;
    return r;
  endfunction

  function automatic row_t hit_row(input logic [NAME_W-1:0] nm, input arp_pkg::ipv4_t ip,
                                   input arp_pkg::mac_addr_t m);
    row_t r;
    r            = '0;
    r.name       = nm;
    r.kind       = K_LOOKUP;
    r.sip        = ip;
    r.chk_result = 1'b1;
    r.exp_val    = 1'b1;
    r.exp_mac    = m;
    return r;
  endfunction

  function automatic row_t inject_row(input logic [NAME_W-1:0] nm, input arp_pkg::arp_oper_t op,
                                      input arp_pkg::mac_addr_t smac, input arp_pkg::ipv4_t sip,
                                      input arp_pkg::ipv4_t tip, input int nbytes,
                                      input int err_at);
    row_t r;
    logic good;
    good        = nbytes >= arp_pkg::ARP_HDR_BYTES && nbytes <= arp_pkg::MAX_RX_BYTES &&
                  err_at < 0;
    r           = '0;
    r.name      = nm;
    r.kind      = K_INJECT;
    r.op        = op;
    r.smac      = smac;
    r.sip       = sip;
    r.tip       = tip;
    r.nbytes    = nbytes;
    r.err_at    = err_at;
    r.exp_frame = good && op == arp_pkg::OPER_REQUEST && tip == DEV_IP;
    r.exp_hdr   = make_hdr(arp_pkg::OPER_REPLY, DEV_MAC, DEV_IP, smac, sip);
    r.exp_dst   = smac;
    return r;
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic send_frame(input arp_pkg::arp_oper_t op, input arp_pkg::mac_addr_t smac,
                            input arp_pkg::ipv4_t sip, input arp_pkg::mac_addr_t tmac,
                            input arp_pkg::ipv4_t tip, input int nbytes, input int err_at);
    logic [arp_pkg::ARP_HDR_BYTES*8-1:0] bits;
    bits = make_hdr(op, smac, sip, tmac, tip);
    for (int i = 0; i < nbytes; i++) begin
      rx.data   = (i < arp_pkg::ARP_HDR_BYTES) ? bits[arp_pkg::ARP_HDR_BYTES*8-1-8*i -: 8] :
                  8'h00;
      rx.valid  = 1'b1;
      rx.err    = (i == err_at);
      rx.is_arp = 1'b1;
      step();
    end
    rx = '0;
    step();
  endtask

  task automatic wait_frame();
    int n;
    n = 0;
    while (!(tx.valid && tx.eof) && n < FRAME_WAIT) begin
      step();
      n++;
    end
  endtask

  task automatic apply_row(input row_t r);
    int n;
    cur = r;
    if (r.kind == K_INJECT) begin
      send_frame(r.op, r.smac, r.sip, '0, r.tip, r.nbytes, r.err_at);
      if (r.exp_frame) wait_frame();
      else repeat (QUIET) step();
    end else begin
      ipv4 = r.sip;
      req  = 1'b1;
      step();
      req = 1'b0;
      n   = 0;
      while (!(val || err) && n < LOOKUP_WAIT) begin
        step();
        n++;
        if (r.kind == K_LOOKUP && tx.valid && tx.eof) begin
          send_frame(arp_pkg::OPER_REPLY, r.smac, r.sip, DEV_MAC, DEV_IP,
                     arp_pkg::ARP_HDR_BYTES, -1);
        end
      end
    end
    step();
    check_stb = 1'b1;
    step();
    check_stb = 1'b0;
  endtask

  // MAC grants three cycles after tx_rdy
  initial begin
    tx_req = 1'b0;
    forever begin
      step();
      if (tx_rdy) begin
        repeat (3) step();
        tx_req = 1'b1;
        step();
        tx_req = 1'b0;
      end
    end
  end

  initial begin
    rst       = 1'b1;
    dev       = '{mac_addr: DEV_MAC, ipv4_addr: DEV_IP};
    rx        = '0;
    ipv4      = '0;
    req       = 1'b0;
    check_stb = 1'b0;
    cur       = '0;
    mac_a     = random_mac();
    mac_a2    = random_mac();
    mac_b     = random_mac();
    mac_c     = random_mac();
    mac_d     = random_mac();
    mac_e     = random_mac();

    rows[0]  = miss_row(NAME_W'("lookup_miss"), IP_A, mac_a, 1'b1);
    rows[1]  = hit_row(NAME_W'("lookup_hit"), IP_A, mac_a);
    rows[2]  = inject_row(NAME_W'("req_for_dev"), arp_pkg::OPER_REQUEST, mac_b, IP_B,
                          DEV_IP, 28, -1);
    rows[3]  = hit_row(NAME_W'("hit_requester"), IP_B, mac_b);
    rows[4]  = inject_row(NAME_W'("req_other"), arp_pkg::OPER_REQUEST, mac_c, IP_C,
                          IP_X, 28, -1);
    rows[5]  = hit_row(NAME_W'("hit_other_snd"), IP_C, mac_c);
    rows[6]  = inject_row(NAME_W'("err_frame"), arp_pkg::OPER_REQUEST, mac_d, IP_D,
                          DEV_IP, 28, 10);
    rows[7]  = miss_row(NAME_W'("miss_err_snd"), IP_D, mac_d, 1'b1);
    rows[8]  = inject_row(NAME_W'("long_frame"), arp_pkg::OPER_REQUEST, mac_e, IP_E,
                          IP_X, 47, -1);
    rows[9]  = miss_row(NAME_W'("miss_long_snd"), IP_E, mac_e, 1'b1);
    rows[10] = inject_row(NAME_W'("relearn"), arp_pkg::OPER_REPLY, mac_a2, IP_A,
                          DEV_IP, 46, -1);
    rows[11] = hit_row(NAME_W'("lookup_new_mac"), IP_A, mac_a2);
    rows[12] = miss_row(NAME_W'("no_reply"), IP_F, '0, 1'b0);

    repeat (16) step();
    rst = 1'b0;
    repeat (5) step();

    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(rows[r]);
      repeat (GAP) step(); // Lets the learning scan settle
    end

    $display("Tests: %0d passed, %0d failed of %0d", pass_cnt, fail_cnt, NUM_ROWS);
    if (fail_cnt == 0 && pass_cnt == NUM_ROWS) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verif/arp_checker.sv */
module arp_checker (
  input  logic               clk,
  input  logic               rst,
  input  arp_pkg::tx_beat_t  tx,
  input  arp_pkg::mac_addr_t dst_mac,
  input  logic               tx_rdy,
  input  logic               tx_req,
  input  arp_pkg::mac_addr_t mac,
  input  logic               val,
  input  logic               err,
  input  logic               check_stb,
  input  logic [127:0]       name,
  input  logic               exp_frame,
  input  arp_pkg::arp_hdr_t  exp_hdr,
  input  arp_pkg::mac_addr_t exp_dst,
  input  logic               chk_result,
  input  logic               exp_val,
  input  logic               exp_err,
  input  arp_pkg::mac_addr_t exp_mac,
  output int                 pass_cnt,
  output int                 fail_cnt
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HDR   = arp_pkg::ARP_HDR_BYTES;
  localparam int FRAME = arp_pkg::TX_FRAME_BYTES;

  arp_pkg::arp_hdr_t  cap_hdr;
  arp_pkg::mac_addr_t cap_dst;
  int                 cnt;
  int                 cap_len;
  int                 nframes;
  int                 faults;
  logic               in_frame;
  logic               err_seen;
  logic               req_q; // tx_req one cycle back

  task automatic clear_test();
    nframes  = 0;
    faults   = 0;
    cap_len  = 0;
    err_seen = 1'b0;
  endtask

  task automatic mismatch(input string what, input logic [223:0] e, input logic [223:0] a);
    $display("** Error %0s: %0s expected %0h actual %0h", name, what, e, a);
    faults++;
  endtask

  task automatic fault(input string msg);
    $display("%0s: %0s", name, msg);
    faults++;
  endtask

  task automatic capture_beat();
    if (tx.sof) begin
      if (in_frame) fault("start of frame seen inside a running frame");
      if (!req_q) fault("start of frame without a grant in the cycle before");
      in_frame = 1'b1;
      cnt      = 0;
      cap_dst  = dst_mac; // Destination goes with the first byte
    end
    if (!in_frame) begin
      fault("byte sent outside a frame");
    end else begin
      cnt++;
      if (cnt <= HDR) begin
        cap_hdr = {cap_hdr[HDR*8-9:0], tx.data};
      end else if (tx.data != 8'h00) begin
        fault("pad byte is not zero");
      end
      if (tx.eof) begin
        nframes++;
        cap_len  = cnt;
        in_frame = 1'b0;
      end
    end
  endtask

  task automatic report();
    if (nframes != (exp_frame ? 1 : 0)) begin
      mismatch("frame count", 224'(exp_frame ? 1 : 0), 224'(nframes));
    end else if (exp_frame) begin
      if (cap_len != FRAME) mismatch("eof at byte", 224'(FRAME), 224'(cap_len));
      if (cap_hdr != exp_hdr) mismatch("header", exp_hdr, cap_hdr);
      if (cap_dst != exp_dst) mismatch("dst_mac", 224'(exp_dst), 224'(cap_dst));
    end
    if (chk_result) begin
      if (val != exp_val) mismatch("val", 224'(exp_val), 224'(val));
      if (err_seen != exp_err) mismatch("err", 224'(exp_err), 224'(err_seen));
      if (exp_val && mac != exp_mac) mismatch("mac", 224'(exp_mac), 224'(mac));
    end
    if (faults == 0) begin
      pass_cnt++;
      $display("%0s: ok", name);
    end else begin
      fail_cnt++;
      $display("%0s: failed with %0d errors", name, faults);
    end
    clear_test();
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pass_cnt = 0;
      fail_cnt = 0;
      in_frame = 1'b0;
      cnt      = 0;
      req_q    = 1'b0;
      clear_test();
    end else begin
      if (err) err_seen = 1'b1; // Pulse is held until the test ends
      if (tx_rdy && tx.valid) fault("tx_rdy still high while a frame is sent");
      if (tx.valid) begin
        capture_beat();
      end else if (in_frame) begin
        fault("frame stopped before eof");
        in_frame = 1'b0;
      end
      if (check_stb) report();
      req_q = tx_req;
    end
  end

endmodule

/* logic/arp_engine.sv */
module arp_engine #(
  parameter int TABLE_DEPTH   = 8,
  parameter int TIMEOUT_TICKS = 1000000
) (
  input  logic               clk,
  input  logic               rst,
  input  arp_pkg::dev_t      dev,
  input  arp_pkg::rx_beat_t  rx,
  output arp_pkg::tx_beat_t  tx,
  output arp_pkg::mac_addr_t dst_mac,
  output logic               tx_rdy,
  input  logic               tx_req,
  input  arp_pkg::ipv4_t     ipv4,
  input  logic               req,
  output arp_pkg::mac_addr_t mac,
  output logic               val,
  output logic               err
);

  arp_pkg::arp_entry_t learn;
  logic                learn_val;
  arp_pkg::arp_hdr_t   req_hdr;
  logic                reply_due;
  arp_pkg::ipv4_t      lookup_ipv4;
  logic                lookup_start;
  logic                lookup_hit;
  logic                lookup_miss;
  arp_pkg::mac_addr_t  lookup_mac;
  arp_pkg::arp_hdr_t   frame_hdr;
  logic                frame_start;
  logic                busy;

  arp_rx_parser parser0 (
    .clk       (clk),
    .rst       (rst),
    .dev       (dev),
    .rx        (rx),
    .learn     (learn),
    .learn_val (learn_val),
    .req_hdr   (req_hdr),
    .reply_due (reply_due)
  );

  arp_cache #(
    .TABLE_DEPTH (TABLE_DEPTH)
  ) cache0 (
    .clk          (clk),
    .rst          (rst),
    .learn        (learn),
    .learn_val    (learn_val),
    .lookup_ipv4  (lookup_ipv4),
    .lookup_start (lookup_start),
    .lookup_hit   (lookup_hit),
    .lookup_miss  (lookup_miss),
    .lookup_mac   (lookup_mac)
  );

  arp_resolver #(
    .TIMEOUT_TICKS (TIMEOUT_TICKS)
  ) resolver0 (
    .clk          (clk),
    .rst          (rst),
    .dev          (dev),
    .ipv4         (ipv4),
    .req          (req),
    .mac          (mac),
    .val          (val),
    .err          (err),
    .lookup_ipv4  (lookup_ipv4),
    .lookup_start (lookup_start),
    .lookup_hit   (lookup_hit),
    .lookup_miss  (lookup_miss),
    .lookup_mac   (lookup_mac),
    .learn        (learn),
    .learn_val    (learn_val),
    .req_hdr      (req_hdr),
    .reply_due    (reply_due),
    .frame_hdr    (frame_hdr),
    .frame_start  (frame_start),
    .busy         (busy)
  );

  arp_tx_framer framer0 (
    .clk         (clk),
    .rst         (rst),
    .dev         (dev),
    .frame_hdr   (frame_hdr),
    .frame_start (frame_start),
    .busy        (busy),
    .tx          (tx),
    .dst_mac     (dst_mac),
    .tx_rdy      (tx_rdy),
    .tx_req      (tx_req)
  );

endmodule

/* logic/arp_resolver.sv */
module arp_resolver #(
  parameter int TIMEOUT_TICKS = 1000000
) (
  input  logic                clk,
  input  logic                rst,
  input  arp_pkg::dev_t       dev,
  input  arp_pkg::ipv4_t      ipv4,
  input  logic                req,
  output arp_pkg::mac_addr_t  mac,
  output logic                val,
  output logic                err,
  output arp_pkg::ipv4_t      lookup_ipv4,
  output logic                lookup_start,
  input  logic                lookup_hit,
  input  logic                lookup_miss,
  input  arp_pkg::mac_addr_t  lookup_mac,
  input  arp_pkg::arp_entry_t learn,
  input  logic                learn_val,
  input  arp_pkg::arp_hdr_t   req_hdr,
  input  logic                reply_due,
  output arp_pkg::arp_hdr_t   frame_hdr,
  output logic                frame_start,
  input  logic                busy
);

  localparam int TW = $clog2(TIMEOUT_TICKS + 1);

  typedef enum logic [1:0] {
    R_IDLE,
    R_LOOKUP,
    R_SEND,
    R_WAIT
  } rstate_t;

  rstate_t           state;
  arp_pkg::ipv4_t    key;
  arp_pkg::arp_hdr_t request_hdr;
  arp_pkg::arp_hdr_t reply_hdr;
  logic              reply_pend;
  logic [TW-1:0]     timer;
  logic              tx_free;
  logic              send_reply;
  logic              send_request;
  logic              learned;

  assign tx_free      = !busy;
  assign send_reply   = reply_pend && tx_free;
  assign send_request = (state == R_SEND) && !reply_pend && tx_free;
  assign learned      = learn_val && (learn.ipv4_addr == key);
  assign lookup_ipv4  = key;

  // Broadcast who-has with unknown target MAC
  assign request_hdr = '{hw_type: arp_pkg::HW_TYPE_ETH, proto: arp_pkg::PROTO_IPV4,
                         hlen: arp_pkg::HW_LEN, plen: arp_pkg::PROTO_LEN,
                         oper: arp_pkg::OPER_REQUEST,
                         src_mac: dev.mac_addr, src_ipv4: dev.ipv4_addr,
                         dst_mac: '0, dst_ipv4: key};

  always_ff @(posedge clk) begin
    if (state == R_IDLE && req) begin
      key <= ipv4;
    end
    if (state == R_LOOKUP && lookup_hit) begin
      mac <= lookup_mac;
    end else if (state == R_WAIT && learned) begin
      mac <= learn.mac_addr;
    end
    if (reply_due) begin // Newest request wins
      reply_hdr <= '{hw_type: arp_pkg::HW_TYPE_ETH, proto: arp_pkg::PROTO_IPV4,
                     hlen: arp_pkg::HW_LEN, plen: arp_pkg::PROTO_LEN,
                     oper: arp_pkg::OPER_REPLY,
                     src_mac: dev.mac_addr, src_ipv4: dev.ipv4_addr,
                     dst_mac: req_hdr.src_mac, dst_ipv4: req_hdr.src_ipv4};
    end
    if (send_reply) begin
      frame_hdr <= reply_hdr;
    end else if (send_request) begin
      frame_hdr <= request_hdr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= R_IDLE;
      val          <= 1'b0;
      err          <= 1'b0;
      lookup_start <= 1'b0;
      frame_start  <= 1'b0;
      reply_pend   <= 1'b0;
      timer        <= '0;
    end else begin
      lookup_start <= 1'b0;
      err          <= 1'b0;
      frame_start  <= send_reply || send_request;
      if (reply_due) begin
        reply_pend <= 1'b1;
      end else if (send_reply) begin
        reply_pend <= 1'b0;
      end
      case (state)
        R_IDLE: begin
          if (req) begin
            val          <= 1'b0;
            lookup_start <= 1'b1;
            state        <= R_LOOKUP;
          end
        end
        R_LOOKUP: begin
          if (lookup_hit) begin
            val   <= 1'b1;
            state <= R_IDLE;
          end else if (lookup_miss) begin
            state <= R_SEND;
          end
        end
        R_SEND: begin
          timer <= '0;
          if (send_request) state <= R_WAIT;
        end
        R_WAIT: begin
          timer <= timer + 1'b1; // Zero while frame_start is high
          if (learned) begin
            val   <= 1'b1;
            state <= R_IDLE;
          end else if (timer == TW'(TIMEOUT_TICKS - 1)) begin
            err   <= 1'b1;
            state <= R_IDLE;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

endmodule

/* logic/arp_cache.sv */
module arp_cache #(
  parameter int TABLE_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  arp_pkg::arp_entry_t learn,
  input  logic                learn_val,
  input  arp_pkg::ipv4_t      lookup_ipv4,
  input  logic                lookup_start,
  output logic                lookup_hit,
  output logic                lookup_miss,
  output arp_pkg::mac_addr_t  lookup_mac
);

  localparam int            AW   = $clog2(TABLE_DEPTH);
  localparam logic [AW-1:0] LAST = AW'(TABLE_DEPTH - 1);

  typedef enum logic [1:0] {
    L_IDLE,
    L_SCAN,
    L_UPDATE,
    L_ADD
  } lstate_t;

  arp_pkg::arp_entry_t    tbl [TABLE_DEPTH];
  logic [TABLE_DEPTH-1:0] vld;

  lstate_t             lstate;
  arp_pkg::arp_entry_t cur;
  logic [AW-1:0]       w_idx;
  logic [AW-1:0]       wr_ptr; // Round robin, oldest entry goes first
  logic                w_match;

  logic                r_busy;
  logic [AW-1:0]       r_idx;
  arp_pkg::ipv4_t      key;
  logic                r_match;

  assign w_match = vld[w_idx] && (tbl[w_idx].ipv4_addr == cur.ipv4_addr);
  assign r_match = vld[r_idx] && (tbl[r_idx].ipv4_addr == key);

  always_ff @(posedge clk) begin
    if (lstate == L_IDLE && learn_val) begin
      cur <= learn;
    end
    if (lstate == L_UPDATE) begin
      tbl[w_idx].mac_addr <= cur.mac_addr;
    end else if (lstate == L_ADD) begin
      tbl[wr_ptr] <= cur;
    end
    if (!r_busy && lookup_start) begin
      key <= lookup_ipv4;
    end
    if (r_busy && r_match) begin
      lookup_mac <= tbl[r_idx].mac_addr;
    end
  end

  // Learning path
  always_ff @(posedge clk) begin
    if (rst) begin
      lstate <= L_IDLE;
      vld    <= '0;
      w_idx  <= '0;
      wr_ptr <= '0;
    end else begin
      case (lstate)
        L_IDLE: begin
          w_idx <= '0;
          if (learn_val) lstate <= L_SCAN;
        end
        L_SCAN: begin
          if (w_match) begin
            lstate <= L_UPDATE; // w_idx stays on the hit
          end else if (w_idx == LAST) begin
            lstate <= L_ADD;
          end else begin
            w_idx <= w_idx + 1'b1;
          end
        end
        L_UPDATE: lstate <= L_IDLE;
        L_ADD: begin
          vld[wr_ptr] <= 1'b1;
          wr_ptr      <= wr_ptr + 1'b1;
          lstate      <= L_IDLE;
        end
        default: lstate <= L_IDLE;
      endcase
    end
  end

  // Lookup path, one entry per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      r_busy      <= 1'b0;
      r_idx       <= '0;
      lookup_hit  <= 1'b0;
      lookup_miss <= 1'b0;
    end else begin
      lookup_hit  <= 1'b0;
      lookup_miss <= 1'b0;
      if (!r_busy) begin
        r_idx <= '0;
        if (lookup_start) r_busy <= 1'b1;
      end else if (r_match) begin
        lookup_hit <= 1'b1;
        r_busy     <= 1'b0;
      end else if (r_idx == LAST) begin
        lookup_miss <= 1'b1;
        r_busy      <= 1'b0;
      end else begin
        r_idx <= r_idx + 1'b1;
      end
    end
  end

endmodule

/* logic/arp_tx_framer.sv */
module arp_tx_framer (
  input  logic               clk,
  input  logic               rst,
  input  arp_pkg::dev_t      dev,
  input  arp_pkg::arp_hdr_t  frame_hdr,
  input  logic               frame_start,
  output logic               busy,
  output arp_pkg::tx_beat_t  tx,
  output arp_pkg::mac_addr_t dst_mac,
  output logic               tx_rdy,
  input  logic               tx_req
);

  localparam int PAD_BITS = (arp_pkg::TX_FRAME_BYTES - arp_pkg::ARP_HDR_BYTES) * 8;

  typedef enum logic [1:0] {
    F_IDLE,
    F_WAIT,
    F_DELAY,
    F_SEND
  } fstate_t;

  fstate_t                                     state;
  logic [arp_pkg::TX_FRAME_BYTES-1:0][7:0]     sr;
  arp_pkg::arp_hdr_t                           hdr_out;
  logic [5:0]                                  byte_cnt;
  logic                                        tx_vld;
  logic                                        tx_sof;
  logic                                        tx_eof;

  // Sender fields always come from the device
  always_comb begin
    hdr_out          = frame_hdr;
    hdr_out.src_mac  = dev.mac_addr;
    hdr_out.src_ipv4 = dev.ipv4_addr;
  end

  always_ff @(posedge clk) begin
    if (state == F_IDLE && frame_start) begin
      sr      <= {hdr_out, {PAD_BITS{1'b0}}};
      dst_mac <= (frame_hdr.oper == arp_pkg::OPER_REQUEST) ?
                 arp_pkg::BROADCAST_MAC : frame_hdr.dst_mac;
    end else if (state == F_SEND) begin
      sr <= {sr[arp_pkg::TX_FRAME_BYTES-2:0], 8'h00};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= F_IDLE;
      byte_cnt <= '0;
      tx_rdy   <= 1'b0;
      tx_vld   <= 1'b0;
      tx_sof   <= 1'b0;
      tx_eof   <= 1'b0;
    end else begin
      case (state)
        F_IDLE: begin
          if (frame_start) begin
            tx_rdy <= 1'b1;
            state  <= F_WAIT;
          end
        end
        F_WAIT: begin
          if (tx_req) begin // Granted by the MAC
            tx_rdy   <= 1'b0;
            tx_vld   <= 1'b1;
            tx_sof   <= 1'b1;
            byte_cnt <= '0;
            state    <= F_SEND;
          end
        end
        F_SEND: begin
          tx_sof   <= 1'b0;
          byte_cnt <= byte_cnt + 6'd1;
          if (byte_cnt == 6'(arp_pkg::TX_FRAME_BYTES - 2)) begin
            tx_eof <= 1'b1;
          end
          if (byte_cnt == 6'(arp_pkg::TX_FRAME_BYTES - 1)) begin
            tx_vld <= 1'b0;
            tx_eof <= 1'b0;
            state  <= F_DELAY;
          end
        end
        F_DELAY: state <= F_IDLE; // One idle beat after eof
        default: state <= F_IDLE;
      endcase
    end
  end

  assign busy = (state != F_IDLE) || frame_start;
  assign tx   = '{data: sr[arp_pkg::TX_FRAME_BYTES-1], valid: tx_vld, sof: tx_sof, eof: tx_eof};

endmodule

/* logic/arp_rx_parser.sv */
module arp_rx_parser (
  input  logic                clk,
  input  logic                rst,
  input  arp_pkg::dev_t       dev,
  input  arp_pkg::rx_beat_t   rx,
  output arp_pkg::arp_entry_t learn,
  output logic                learn_val,
  output arp_pkg::arp_hdr_t   req_hdr,
  output logic                reply_due
);

  arp_pkg::arp_hdr_t hdr;
  logic [5:0]        byte_cnt;
  logic              in_frame;
  logic              bad;
  logic              frame_end;
  logic              frame_ok;
  logic              for_us;

  assign frame_end = in_frame && !rx.valid;
  assign frame_ok  = !bad && (byte_cnt >= 6'(arp_pkg::ARP_HDR_BYTES));
  assign for_us    = (hdr.oper == arp_pkg::OPER_REQUEST) &&
                     (hdr.proto == arp_pkg::PROTO_IPV4) &&
                     (hdr.dst_ipv4 == dev.ipv4_addr);

  // Only the first 28 bytes land in the header, padding falls off
  always_ff @(posedge clk) begin
    if (rx.valid && byte_cnt < 6'(arp_pkg::ARP_HDR_BYTES)) begin
      hdr <= {hdr[arp_pkg::ARP_HDR_BYTES*8-9:0], rx.data};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt  <= '0;
      in_frame  <= 1'b0;
      bad       <= 1'b0;
      learn_val <= 1'b0;
      reply_due <= 1'b0;
    end else begin
      learn_val <= frame_end && frame_ok;
      reply_due <= frame_end && frame_ok && for_us;
      if (frame_end) begin
        in_frame <= 1'b0;
        byte_cnt <= '0;
        bad      <= 1'b0;
      end else if (rx.valid) begin
        in_frame <= 1'b1;
        if (byte_cnt == 6'(arp_pkg::MAX_RX_BYTES)) begin
          bad <= 1'b1; // Too long
        end else begin
          byte_cnt <= byte_cnt + 6'd1;
        end
        if (rx.err || !rx.is_arp) begin
          bad <= 1'b1;
        end
      end
    end
  end

  // Header holds until the next frame shifts in
  assign learn   = '{ipv4_addr: hdr.src_ipv4, mac_addr: hdr.src_mac};
  assign req_hdr = hdr;

endmodule

/* logic/arp_pkg.sv */
package arp_pkg;

  typedef logic [31:0] ipv4_t;     // MSB is the first byte on the wire
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] arp_oper_t;

  localparam arp_oper_t   OPER_REQUEST = 16'd1;
  localparam arp_oper_t   OPER_REPLY   = 16'd2;
  localparam logic [15:0] HW_TYPE_ETH  = 16'd1;
  localparam logic [15:0] PROTO_IPV4   = 16'h0800;
  localparam logic [7:0]  HW_LEN       = 8'd6;
  localparam logic [7:0]  PROTO_LEN    = 8'd4;

  localparam int ARP_HDR_BYTES  = 28;
  localparam int TX_FRAME_BYTES = 46; // Header plus zero padding
  localparam int MAX_RX_BYTES   = 46;

  localparam mac_addr_t BROADCAST_MAC = 48'hffff_ffff_ffff;

  // Wire order, first field is sent first
  typedef struct packed {
    logic [15:0] hw_type;
    logic [15:0] proto;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    arp_oper_t   oper;
    mac_addr_t   src_mac;
    ipv4_t       src_ipv4;
    mac_addr_t   dst_mac;
    ipv4_t       dst_ipv4;
  } arp_hdr_t;

  typedef struct packed {
    mac_addr_t mac_addr;
    ipv4_t     ipv4_addr;
  } dev_t;

  typedef struct packed {
    ipv4_t     ipv4_addr;
    mac_addr_t mac_addr;
  } arp_entry_t;

  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       err;
    logic       is_arp; // Ethertype seen by the MAC was ARP
  } rx_beat_t;

  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       sof;
    logic       eof;
  } tx_beat_t;

endpackage
